//--- digit_recog_top.f
hw/vip_pkg.sv
hw/pixel_binarize.sv
hw/col_projector.sv
hw/row_projector.sv
hw/segment_sampler.sv
hw/digit_recog_top.sv
dv/tb_video_src.sv
dv/tb_digit_recog.sv

//--- dv/tb_digit_recog.sv
`timescale 1ns/10ps

module tb_digit_recog;

    localparam int FRAME_CYCLES = 2400;     // 2384 per frame plus margin
    localparam int NUM_FRAMES   = 12;       // six tests of two frames
    localparam int MAX_CYCLES   = NUM_FRAMES * FRAME_CYCLES;
    localparam logic [15:0] ALL_NONE = {vip_pkg::NUM_COL{vip_pkg::NO_DIGIT}};

    logic                                         clk = 1'b0;
    logic                                         arst_n;
    logic                                         frame_vsync;
    logic                                         frame_de;
    logic [15:0]                                  pixel_rgb;
    logic [vip_pkg::NUM_COL*vip_pkg::DIGIT_W-1:0] digits;
    logic                                         digit_valid;

    string       test_name   = "reset";
    logic [15:0] exp_digits  = ALL_NONE;
    logic        check_en    = 1'b0;        // second frame of a test
    logic        first_frame = 1'b1;
    int          errors      = 0;
    int          checks      = 0;
    int          pulses      = 0;
    int          cycles      = 0;

    always #4 clk = ~clk;

    digit_recog_top digit_recog_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_vsync (frame_vsync),
        .frame_de    (frame_de),
        .pixel_rgb   (pixel_rgb),
        .digits      (digits),
        .digit_valid (digit_valid)
    );

    tb_video_src u_video_src (
        .clk         (clk),
        .frame_vsync (frame_vsync),
        .frame_de    (frame_de),
        .pixel_rgb   (pixel_rgb)
    );

    // empty slots close up to the left, glyphs other than 0..9 read as none
    function automatic logic [15:0] expected_digits(input logic [15:0] glyphs);
        logic [15:0] res;
        logic [3:0]  g;
        int          n;
        res = ALL_NONE;
        n   = 0;
        for (int s = 0; s < vip_pkg::NUM_COL; s++) begin
            g = glyphs[s*4 +: 4];
            if (g != 4'hf) begin
                res[n*4 +: 4] = (g <= 4'd9) ? g : vip_pkg::NO_DIGIT;
                n++;
            end
        end
        return res;
    endfunction

    // --------------------------------------------------------------------------
    // checks
    a_first_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        first_frame |-> !digit_valid)
        else begin
            errors++;
            $display("digit_valid pulsed during the first frame after reset");
        end

    a_reset_digits: assert property (@(posedge clk) disable iff (!arst_n)
        first_frame |-> digits == ALL_NONE)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", test_name, ALL_NONE, digits);
        end

    a_pulse_time: assert property (@(posedge clk) disable iff (!arst_n)
        check_en && $rose(frame_vsync) |-> ##2 digit_valid)   // binarize plus sampler
        else begin
            errors++;
            $display("no digit_valid two cycles after the frame end in %s", test_name);
        end

    a_digits: assert property (@(posedge clk) disable iff (!arst_n)
        check_en && digit_valid |-> digits == exp_digits)
        else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", test_name, exp_digits, digits);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (digit_valid)
            pulses <= pulses + 1;
        if (digit_valid && check_en)
            checks <= checks + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // same image for two frames, reported at the end of the second
    task automatic run_test(input string name, input logic [15:0] glyphs);
        int base;
        test_name = name;
        check_en  = 1'b0;
        u_video_src.show_frame(glyphs);         // boxes only
        first_frame = 1'b0;
        exp_digits  = expected_digits(glyphs);
        check_en    = 1'b1;
        base        = pulses;
        u_video_src.show_frame(glyphs);         // sampled and decoded
        a_one_pulse: assert (pulses - base == 1)
            else begin
                errors++;
                $display("[FAIL] %s pulses: expected 1, actual %0d", name, pulses - base);
            end
    endtask

    // --------------------------------------------------------------------------
    // sequence, glyph slot 0 in the low nibble
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_test("digits_0123", 16'h3210);      // first frame also checks reset state
        run_test("digits_4567", 16'h7654);
        run_test("digits_8910", 16'h0198);      // narrow box in slot 2
        run_test("two_digits", 16'h8f2f);       // gaps close up
        run_test("seg_a_only", 16'hff3e);       // 3 keeps the row span full height
        run_test("light_frame", 16'hffff);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- dv/tb_video_src.sv
`timescale 1ns/10ps

module tb_video_src (
    input  logic        clk,
    output logic        frame_vsync,
    output logic        frame_de,
    output logic [15:0] pixel_rgb
);

    // --------------------------------------------------------------------------
    // glyph layout, one digit row
    localparam int GLYPH_W     = 12;
    localparam int GLYPH_H     = 20;
    localparam int BAR         = 3;         // segment bar thickness
    localparam int GLYPH_X0    = 4;         // left edge of slot 0
    localparam int GLYPH_PITCH = 15;
    localparam int GLYPH_Y0    = 6;
    localparam int H_GAP       = 8;         // de low between lines
    localparam int V_BLANK     = 80;        // vsync high after the last line

    logic [31:0] rng = 32'hba00_68a1;

    initial begin
        frame_vsync = 1'b0;
        frame_de    = 1'b0;
        pixel_rgb   = 16'h0000;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // random member of the dark or light class
    function automatic logic [15:0] pick_color(input logic dark, input logic [31:0] r);
        logic [4:0] red;
        logic [4:0] grn;
        logic [4:0] blu;
        if (dark) begin
            red = 5'(r[7:0] % 5);               // 0..4 per field, sum at most 12
            grn = 5'(r[15:8] % 5);
            blu = 5'(r[23:16] % 5);
        end else begin
            red = 5'(14 + r[7:0] % 18);         // 14..31 per field, sum at least 42
            grn = 5'(14 + r[15:8] % 18);
            blu = 5'(14 + r[23:16] % 18);
        end
        return {red, grn, r[24], blu};          // green lsb is noise only
    endfunction

    // bits {g, f, e, d, c, b, a}
    function automatic logic [6:0] segment_mask(input logic [3:0] glyph);
        case (glyph)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;              // b and c form the right bar
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            4'he:    return 7'h01;              // top bar alone
            default: return 7'h00;              // empty slot
        endcase
    endfunction

    function automatic logic segment_hit(input logic [6:0] mask, input int gx, input int gy);
        logic upper;
        logic left;
        logic right;
        upper = gy < GLYPH_H / 2;
        left  = gx < BAR;
        right = gx >= GLYPH_W - BAR;
        return (mask[0] && gy < BAR)                            // a
            || (mask[1] && right && upper)                      // b
            || (mask[2] && right && !upper)                     // c
            || (mask[3] && gy >= GLYPH_H - BAR)                 // d
            || (mask[4] && left && !upper)                      // e
            || (mask[5] && left && upper)                       // f
            || (mask[6] && gy >= 8 && gy < 8 + BAR);            // g, rows 8..10
    endfunction

    function automatic logic pixel_is_dark(input logic [15:0] glyphs, input int x, input int y);
        int   x0;
        logic dark;
        dark = 1'b0;
        for (int s = 0; s < vip_pkg::NUM_COL; s++) begin
            x0 = GLYPH_X0 + GLYPH_PITCH * s;
            if (x >= x0 && x < x0 + GLYPH_W && y >= GLYPH_Y0 && y < GLYPH_Y0 + GLYPH_H)
                dark = segment_hit(segment_mask(glyphs[s*4 +: 4]), x - x0, y - GLYPH_Y0);
        end
        return dark;
    endfunction

    // --------------------------------------------------------------------------
    // one full frame, active lines then vertical blanking
    task automatic show_frame(input logic [15:0] glyphs);
        logic dark;
        for (int y = 0; y < vip_pkg::V_PIXEL; y++) begin
            for (int x = 0; x < vip_pkg::H_PIXEL + H_GAP; x++) begin
                @(negedge clk);
                frame_vsync = 1'b0;
                rng         = next_random(rng);
                dark        = pixel_is_dark(glyphs, x, y);
                frame_de    = x < vip_pkg::H_PIXEL;
                pixel_rgb   = (x < vip_pkg::H_PIXEL) ? pick_color(dark, rng) : 16'h0000;
            end
        end
        for (int v = 0; v < V_BLANK; v++) begin
            @(negedge clk);
            frame_de    = 1'b0;
            frame_vsync = 1'b1;                 // rise is the frame end
        end
    endtask

endmodule

//--- hw/col_projector.sv
`timescale 1ns/10ps

module col_projector (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        pix_dark,
    input  logic                                        pix_de,
    input  logic [vip_pkg::XW-1:0]                      pix_x,
    input  logic                                        frame_end,
    output logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_left,
    output logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_right,
    output logic [2:0]                                  col_count,  // spans found
    output logic                                        cols_valid  // spans complete
);

    logic [vip_pkg::H_PIXEL-1:0] flags;      // dark columns, frame in progress
    logic [vip_pkg::H_PIXEL-1:0] hit;
    logic [vip_pkg::H_PIXEL-1:0] scan_bits;  // copy, shifted right per step
    logic                        scanning;
    logic [vip_pkg::XW-1:0]      scan_idx;   // column under test
    logic                        in_run;
    logic [vip_pkg::XW-1:0]      run_start;
    logic                        cur;
    logic                        last_col;
    logic                        close_run;
    logic [vip_pkg::XW-1:0]      run_lo;
    logic [vip_pkg::XW-1:0]      run_hi;

    assign hit = (pix_de && pix_dark) ? {{(vip_pkg::H_PIXEL-1){1'b0}}, 1'b1} << pix_x : '0;

    // --------------------------------------------------------------------------
    // run detection on the walked copy
    assign cur       = scan_bits[0];
    assign last_col  = scan_idx == vip_pkg::H_PIXEL - 1;
    assign close_run = scanning && ((in_run && !cur) || (cur && last_col));  // right edge closes
    assign run_lo    = in_run ? run_start : scan_idx;
    assign run_hi    = cur ? scan_idx : scan_idx - 1'b1;   // run ended on previous column

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags      <= '0;
            scan_bits  <= '0;
            scanning   <= 1'b0;
            scan_idx   <= '0;
            in_run     <= 1'b0;
            run_start  <= '0;
            col_left   <= '0;
            col_right  <= '0;
            col_count  <= '0;
            cols_valid <= 1'b0;
        end else begin
            cols_valid <= scanning && last_col;  // H_PIXEL + 1 after frame_end
            if (frame_end) begin
                flags     <= '0;
                scan_bits <= flags | hit;       // keep a pixel landing on this cycle
                scanning  <= 1'b1;
                scan_idx  <= '0;
                in_run    <= 1'b0;
                col_left  <= '0;
                col_right <= '0;
                col_count <= '0;
            end else begin
                flags <= flags | hit;
                if (scanning) begin
                    scan_bits <= scan_bits >> 1;
                    scan_idx  <= scan_idx + 1'b1;
                    scanning  <= !last_col;
                    in_run    <= cur && !last_col;
                    if (cur && !in_run)
                        run_start <= scan_idx;
                    if (close_run && col_count < vip_pkg::NUM_COL) begin  // extra runs dropped
                        col_left[col_count]  <= run_lo;
                        col_right[col_count] <= run_hi;
                        col_count            <= col_count + 1'b1;
                    end
                end
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
        col_count <= vip_pkg::NUM_COL)
        else $error("col_count above NUM_COL");

endmodule

//--- hw/digit_recog_top.sv
`timescale 1ns/10ps

module digit_recog_top (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         frame_vsync,
    input  logic                                         frame_de,
    input  logic [15:0]                                  pixel_rgb,
    output logic [vip_pkg::NUM_COL*vip_pkg::DIGIT_W-1:0] digits,
    output logic                                         digit_valid
);

    logic                                         pix_dark;
    logic                                         pix_de;
    logic [vip_pkg::XW-1:0]                       pix_x;
    logic [vip_pkg::YW-1:0]                       pix_y;
    logic                                         frame_end;
    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_left;
    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_right;
    logic [2:0]                                   col_count;
    logic                                         cols_valid;
    logic [vip_pkg::YW-1:0]                       row_top;
    logic [vip_pkg::YW-1:0]                       row_bottom;
    logic                                         row_found;

    // --------------------------------------------------------------------------
    // pixel marking, then the two projections side by side
    pixel_binarize u_pixel_binarize (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_vsync (frame_vsync),
        .frame_de    (frame_de),
        .pixel_rgb   (pixel_rgb),
        .pix_dark    (pix_dark),
        .pix_de      (pix_de),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_end   (frame_end)
    );

    col_projector u_col_projector (
        .clk        (clk),
        .arst_n     (arst_n),
        .pix_dark   (pix_dark),
        .pix_de     (pix_de),
        .pix_x      (pix_x),
        .frame_end  (frame_end),
        .col_left   (col_left),
        .col_right  (col_right),
        .col_count  (col_count),
        .cols_valid (cols_valid)
    );

    row_projector u_row_projector (
        .clk        (clk),
        .arst_n     (arst_n),
        .pix_dark   (pix_dark),
        .pix_de     (pix_de),
        .pix_y      (pix_y),
        .frame_end  (frame_end),
        .row_top    (row_top),
        .row_bottom (row_bottom),
        .row_found  (row_found)
    );

    // boxes from frame N, sampled in frame N+1
    segment_sampler u_segment_sampler (
        .clk         (clk),
        .arst_n      (arst_n),
        .pix_dark    (pix_dark),
        .pix_de      (pix_de),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_end   (frame_end),
        .col_left    (col_left),
        .col_right   (col_right),
        .col_count   (col_count),
        .cols_valid  (cols_valid),
        .row_top     (row_top),
        .row_bottom  (row_bottom),
        .row_found   (row_found),
        .digits      (digits),
        .digit_valid (digit_valid)
    );

endmodule

//--- hw/pixel_binarize.sv
`timescale 1ns/10ps

module pixel_binarize (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   frame_vsync,  // high in vertical blanking
    input  logic                   frame_de,     // active pixel
    input  logic [15:0]            pixel_rgb,    // rgb565
    output logic                   pix_dark,
    output logic                   pix_de,
    output logic [vip_pkg::XW-1:0] pix_x,
    output logic [vip_pkg::YW-1:0] pix_y,
    output logic                   frame_end     // one cycle, vsync rise
);

    logic [6:0]              luma;    // up to 31 + 31 + 31
    logic                    vsync_d;
    logic [vip_pkg::XW-1:0]  x_cnt;   // position of the incoming pixel
    logic [vip_pkg::YW-1:0]  y_cnt;

    // green keeps its upper five bits so all three fields weigh the same
    assign luma = 7'(pixel_rgb[15:11]) + 7'(pixel_rgb[10:6]) + 7'(pixel_rgb[4:0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_d   <= 1'b0;
            pix_dark  <= 1'b0;
            pix_de    <= 1'b0;
            pix_x     <= '0;
            pix_y     <= '0;
            frame_end <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
        end else begin
            vsync_d   <= frame_vsync;
            pix_dark  <= luma < vip_pkg::DARK_THRESH;
            pix_de    <= frame_de;
            pix_x     <= x_cnt;
            pix_y     <= y_cnt;
            frame_end <= frame_vsync && !vsync_d;
            if (frame_vsync && !vsync_d) begin      // new frame, restart at origin
                x_cnt <= '0;
                y_cnt <= '0;
            end else if (frame_de) begin
                x_cnt <= x_cnt + 1'b1;
            end else if (pix_de) begin              // de just fell, next line
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // input framing checks
    a_de_vsync: assert property (@(posedge clk) disable iff (!arst_n)
        !(frame_de && frame_vsync))
        else $error("frame_de overlaps frame_vsync");

    a_x_range: assert property (@(posedge clk) disable iff (!arst_n)
        pix_de |-> pix_x < vip_pkg::H_PIXEL)
        else $error("line longer than H_PIXEL");

endmodule

//--- hw/row_projector.sv
`timescale 1ns/10ps

module row_projector (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pix_dark,
    input  logic                   pix_de,
    input  logic [vip_pkg::YW-1:0] pix_y,
    input  logic                   frame_end,
    output logic [vip_pkg::YW-1:0] row_top,     // first dark line, last frame
    output logic [vip_pkg::YW-1:0] row_bottom,  // last dark line
    output logic                   row_found
);

    logic                   hit;
    logic                   seen;    // any dark pixel this frame
    logic                   seen_n;
    logic [vip_pkg::YW-1:0] min_y;
    logic [vip_pkg::YW-1:0] max_y;
    logic [vip_pkg::YW-1:0] min_n;
    logic [vip_pkg::YW-1:0] max_n;

    assign hit = pix_de && pix_dark;

    always_comb begin
        seen_n = seen || hit;
        min_n  = min_y;
        max_n  = max_y;
        if (hit && (!seen || pix_y < min_y))
            min_n = pix_y;
        if (hit && (!seen || pix_y > max_y))
            max_n = pix_y;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen       <= 1'b0;
            min_y      <= '0;
            max_y      <= '0;
            row_top    <= '0;
            row_bottom <= '0;
            row_found  <= 1'b0;
        end else if (frame_end) begin
            row_top    <= min_n;                // span of the frame just closed
            row_bottom <= max_n;
            row_found  <= seen_n;
            seen       <= 1'b0;
        end else begin
            seen  <= seen_n;
            min_y <= min_n;
            max_y <= max_n;
        end
    end

    a_span_order: assert property (@(posedge clk) disable iff (!arst_n)
        row_found |-> row_top <= row_bottom)
        else $error("row span inverted");

endmodule

//--- hw/segment_sampler.sv
`timescale 1ns/10ps

module segment_sampler (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         pix_dark,
    input  logic                                         pix_de,
    input  logic [vip_pkg::XW-1:0]                       pix_x,
    input  logic [vip_pkg::YW-1:0]                       pix_y,
    input  logic                                         frame_end,
    input  logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_left,
    input  logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] col_right,
    input  logic [2:0]                                   col_count,
    input  logic                                         cols_valid,
    input  logic [vip_pkg::YW-1:0]                       row_top,
    input  logic [vip_pkg::YW-1:0]                       row_bottom,
    input  logic                                         row_found,
    output logic [vip_pkg::NUM_COL*vip_pkg::DIGIT_W-1:0] digits,     // slot 0 leftmost
    output logic                                         digit_valid
);

    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] box_w;
    logic [vip_pkg::YW-1:0]                       box_h;
    logic [vip_pkg::YW+1:0]                       h_3q;     // 3h/4
    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] xl;       // f, e column
    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] xm;       // a, g, d column
    logic [vip_pkg::NUM_COL-1:0][vip_pkg::XW-1:0] xr;       // b, c column
    logic [vip_pkg::YW-1:0]                       ya;       // a row
    logic [vip_pkg::YW-1:0]                       yf;       // f and b row
    logic [vip_pkg::YW-1:0]                       yg;       // g row
    logic [vip_pkg::YW-1:0]                       ye;       // e and c row
    logic [vip_pkg::YW-1:0]                       yd;       // d row
    logic [vip_pkg::NUM_COL-1:0]                  narrow;   // reads as 1
    logic [vip_pkg::NUM_COL-1:0]                  box_ok;
    logic [vip_pkg::NUM_COL-1:0][6:0]             hit;
    logic [vip_pkg::NUM_COL-1:0][6:0]             seg;      // {a,b,c,d,e,f,g} seen dark
    logic [vip_pkg::NUM_COL-1:0][6:0]             seg_now;
    logic                                         loaded;   // boxes in place for this frame

    function automatic logic [vip_pkg::DIGIT_W-1:0] decode(input logic [6:0] pat);
        logic [vip_pkg::DIGIT_W-1:0] code;
        code = vip_pkg::NO_DIGIT;
        for (int d = 0; d < 10; d++)
            if (pat == vip_pkg::SEG_TABLE[d])
                code = 4'(d);
        return code;
    endfunction

    // --------------------------------------------------------------------------
    // box geometry and sample point hits
    always_comb begin
        box_h = row_bottom - row_top;
        h_3q  = ({2'b00, box_h} + {1'b0, box_h, 1'b0}) >> 2;
        for (int i = 0; i < vip_pkg::NUM_COL; i++) begin
            box_w[i]   = col_right[i] - col_left[i];
            hit[i][6]  = pix_y == ya && pix_x == xm[i];     // a
            hit[i][5]  = pix_y == yf && pix_x == xr[i];     // b
            hit[i][4]  = pix_y == ye && pix_x == xr[i];     // c
            hit[i][3]  = pix_y == yd && pix_x == xm[i];     // d
            hit[i][2]  = pix_y == ye && pix_x == xl[i];     // e
            hit[i][1]  = pix_y == yf && pix_x == xl[i];     // f
            hit[i][0]  = pix_y == yg && pix_x == xm[i];     // g
            seg_now[i] = seg[i] | (hit[i] & {7{pix_de && pix_dark}});
        end
    end

    always_ff @(posedge clk) begin
        if (cols_valid) begin                   // boxes of frame N
            ya <= row_top + 1'b1;
            yf <= row_top + (box_h >> 2);
            yg <= row_top + (box_h >> 1);
            ye <= row_top + h_3q[vip_pkg::YW-1:0];
            yd <= row_bottom - 1'b1;
            for (int i = 0; i < vip_pkg::NUM_COL; i++) begin
                xl[i]     <= col_left[i] + 1'b1;
                xm[i]     <= col_left[i] + (box_w[i] >> 1);
                xr[i]     <= col_right[i] - 1'b1;
                narrow[i] <= box_w[i] < (box_h >> vip_pkg::ONE_RATIO);
            end
            seg <= '0;
        end else begin
            seg <= seg_now;                     // sampled through frame N+1
        end
    end

    // --------------------------------------------------------------------------
    // decode at the frame end after loading
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            loaded      <= 1'b0;
            box_ok      <= '0;
            digits      <= {vip_pkg::NUM_COL{vip_pkg::NO_DIGIT}};
            digit_valid <= 1'b0;
        end else begin
            digit_valid <= frame_end && loaded;
            if (cols_valid) begin
                loaded <= 1'b1;
                for (int i = 0; i < vip_pkg::NUM_COL; i++)
                    box_ok[i] <= row_found && (i < col_count);
            end else if (frame_end) begin
                loaded <= 1'b0;                 // unloaded frame end only arms
                if (loaded) begin
                    for (int i = 0; i < vip_pkg::NUM_COL; i++)
                        digits[i*vip_pkg::DIGIT_W +: vip_pkg::DIGIT_W] <=
                            !box_ok[i] ? vip_pkg::NO_DIGIT :
                            narrow[i]  ? 4'd1 : decode(seg_now[i]);
                end
            end
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        digit_valid |=> !digit_valid)
        else $error("digit_valid longer than one cycle");

endmodule

//--- hw/vip_pkg.sv
package vip_pkg;

    // --------------------------------------------------------------------------
    // frame geometry
    localparam int H_PIXEL     = 64;        // active pixels per line
    localparam int V_PIXEL     = 32;        // active lines per frame
    localparam int XW          = 7;         // x coordinate width
    localparam int YW          = 6;         // y coordinate width

    // --------------------------------------------------------------------------
    // recognition
    localparam int NUM_COL     = 4;         // digit slots, one row only
    localparam int DARK_THRESH = 24;        // r5 + g[5:1] + b5 below this is dark
    localparam int DIGIT_W     = 4;
    localparam int ONE_RATIO   = 2;         // narrower than h >> 2 reads as 1

    localparam logic [DIGIT_W-1:0] NO_DIGIT = 4'hf;  // empty slot or no match

    // segment bits {a, b, c, d, e, f, g}, index = digit value
    localparam logic [6:0] SEG_TABLE [10] = '{
        7'h7e,                              // 0
        7'h30,                              // 1
        7'h6d,                              // 2
        7'h79,                              // 3
        7'h33,                              // 4
        7'h5b,                              // 5
        7'h5f,                              // 6, with tail a
        7'h70,                              // 7
        7'h7f,                              // 8
        7'h7b                               // 9, with tail d
    };

endpackage
